//--- rtl/mmio_pkg.sv
package mmio_pkg;

    // Wishbone classic request, master to slave.
    typedef struct packed {
        logic        cyc;            // Bus cycle in progress.
        logic        stb;            // Request valid.
        logic        we;             // Write when set.
        logic [31:0] adr;            // Byte address.
        logic [31:0] dat;            // Write data.
        logic [3:0]  sel;            // Byte lanes.
    } wb_req_t;

    // Wishbone classic response, slave to master.
    typedef struct packed {
        logic        ack;            // Access done.
        logic        err;            // Access refused.
        logic [31:0] dat;            // Read data, valid with ack.
    } wb_rsp_t;

    // Where a bus address lands.
    typedef enum logic [1:0] {
        TGT_MEM,                     // Data memory.
        TGT_SPI,                     // SPI register block.
        TGT_NONE                     // Unmapped.
    } bus_tgt_e;

    // SPI master phases.
    typedef enum logic [2:0] {
        SPI_IDLE,                    // Waiting for start.
        SPI_LEAD,                    // Slave selected, first bit on mosi.
        SPI_HIGH,                    // Sck high half period.
        SPI_LOW,                     // Sck low half period.
        SPI_DONE                     // Byte complete, select released.
    } spi_state_e;

    // Memory map.
    localparam logic [31:0] IO_BASE      = 32'h8000_0000;  // Bit 31 selects I/O.
    localparam logic [31:0] SPI_DATA_OFS = 32'h0000_0000;  // Tx on write, rx on read.
    localparam logic [31:0] SPI_STAT_OFS = 32'h0000_0004;  // Busy in bit 0, ready in bit 1.

endpackage

//--- rtl/mem_map_io_dec.sv
`timescale 1ns/1ps

module mem_map_io_dec import mmio_pkg::*; #(
    parameter int MEM_WORDS = 256               // Data memory depth in words.
) (
    input  logic        clk,
    input  logic        i_arst_n,
    input  wb_req_t     i_req,                  // Bus request.
    input  logic [31:0] i_mem_rdata,            // Data memory read register.
    input  logic [31:0] i_spi_rdata,            // SPI register read value.
    input  logic        i_spi_busy,             // Transfer in progress.
    output logic        o_mem_we,               // Data memory write strobe.
    output logic [3:0]  o_mem_sel,              // Data memory write lanes.
    output logic        o_spi_wr,               // SPI register write strobe.
    output logic        o_spi_rd,               // SPI register read strobe.
    output wb_rsp_t     o_rsp                   // Registered bus response.
);
    bus_tgt_e tgt;                              // Decoded target.
    bus_tgt_e rd_tgt_q;                         // Read data source for the response cycle.
    logic     spi_data_adr;                     // Hits the SPI data register.
    logic     spi_stat_adr;                     // Hits the SPI status register.
    logic     lanes_ok;                         // Lane pattern fits the address.
    logic     acc_ok;                           // Access will be acked.
    logic     rsp_pend;                         // Response out, request still held.
    logic     req_new;                          // First cycle of a request.
    logic     ack_q;
    logic     err_q;

    assign spi_data_adr = (i_req.adr == IO_BASE + SPI_DATA_OFS);
    assign spi_stat_adr = (i_req.adr == IO_BASE + SPI_STAT_OFS);

    always_comb begin
        if (i_req.adr[31]) begin                // I/O region, two registers only.
            tgt = (spi_data_adr || spi_stat_adr) ? TGT_SPI : TGT_NONE;
        end else if (i_req.adr[31:2] < 30'(MEM_WORDS)) begin
            tgt = TGT_MEM;
        end else begin
            tgt = TGT_NONE;                     // Past the end of the memory.
        end
    end

    // Lanes must sit where the low address bits point.
    always_comb begin
        case (i_req.sel)
            4'b1111: lanes_ok = (i_req.adr[1:0] == 2'd0);  // Word.
            4'b0011: lanes_ok = (i_req.adr[1:0] == 2'd0);  // Low halfword.
            4'b1100: lanes_ok = (i_req.adr[1:0] == 2'd2);  // High halfword.
            4'b0001: lanes_ok = (i_req.adr[1:0] == 2'd0);  // Byte 0.
            4'b0010: lanes_ok = (i_req.adr[1:0] == 2'd1);  // Byte 1.
            4'b0100: lanes_ok = (i_req.adr[1:0] == 2'd2);  // Byte 2.
            4'b1000: lanes_ok = (i_req.adr[1:0] == 2'd3);  // Byte 3.
            default: lanes_ok = 1'b0;
        endcase
    end

    always_comb begin
        case (tgt)
            TGT_MEM: acc_ok = lanes_ok;
            TGT_SPI: acc_ok = (i_req.sel == 4'b1111)          // Full word only.
                              && !(i_req.we && spi_data_adr && i_spi_busy);
            default: acc_ok = 1'b0;
        endcase
    end

    assign rsp_pend = ack_q | err_q;            // Master still sees this cycle's response.
    assign req_new  = i_req.cyc && i_req.stb && !rsp_pend;

    assign o_mem_we  = req_new && acc_ok && (tgt == TGT_MEM) && i_req.we;
    assign o_mem_sel = i_req.sel;
    assign o_spi_wr  = req_new && acc_ok && (tgt == TGT_SPI) && i_req.we;
    assign o_spi_rd  = req_new && acc_ok && (tgt == TGT_SPI) && !i_req.we;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ack_q    <= 1'b0;
            err_q    <= 1'b0;
            rd_tgt_q <= TGT_NONE;
        end else begin
            ack_q    <= req_new && acc_ok;
            err_q    <= req_new && !acc_ok;
            rd_tgt_q <= (req_new && acc_ok && !i_req.we) ? tgt : TGT_NONE;  // Writes return 0.
        end
    end

    always_comb begin
        o_rsp.ack = ack_q;
        o_rsp.err = err_q;
        case (rd_tgt_q)
            TGT_MEM: o_rsp.dat = i_mem_rdata;  // Both sources load at the request edge.
            TGT_SPI: o_rsp.dat = i_spi_rdata;
            default: o_rsp.dat = 32'h0;
        endcase
    end

endmodule

//--- rtl/data_mem.sv
`timescale 1ns/1ps

module data_mem #(
    parameter int MEM_WORDS = 256               // Depth in 32-bit words.
) (
    input  logic        clk,
    input  logic        i_we,                   // Write strobe, one cycle.
    input  logic [3:0]  i_sel,                  // Byte lanes to write.
    input  logic [31:0] i_addr,                 // Byte address.
    input  logic [31:0] i_wdata,                // Write data, lane aligned.
    output logic [31:0] o_rdata                 // Whole addressed word, registered.
);
    localparam int ADDR_W = $clog2(MEM_WORDS);  // Word index width.

    logic [31:0]       mem_q [MEM_WORDS];       // Storage, not reset.
    logic [ADDR_W-1:0] word_idx;                // Word picked by the address.
    logic [31:0]       lane_mask;               // Bits that a write touches.
    logic [31:0]       wr_word;                 // Merged word to store.
    logic [31:0]       rdata_q;

    assign word_idx = i_addr[ADDR_W+1:2];       // Drop the byte offset.

    // Expand the lanes into a bit mask.
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            lane_mask[8*b +: 8] = {8{i_sel[b]}};
        end
    end

    // Old bits outside the enabled lanes survive
    assign wr_word = (i_wdata & lane_mask) | (mem_q[word_idx] & ~lane_mask);

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem_q[word_idx] <= wr_word;         // Lanes land at the request edge.
        end
    end

    // Read register follows the address every edge, old data on a write.
    always_ff @(posedge clk) begin
        rdata_q <= mem_q[word_idx];
    end

    assign o_rdata = rdata_q;

endmodule

//--- rtl/spi_sck_timer.sv
`timescale 1ns/1ps

module spi_sck_timer #(
    parameter int SCK_HALF_CLKS = 4             // Clk cycles per sck half period.
) (
    input  logic clk,
    input  logic i_arst_n,
    input  logic i_run,                         // Transfer active.
    output logic o_tick                         // End of a half period.
);
    localparam int              CNT_W  = $clog2(SCK_HALF_CLKS);
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(SCK_HALF_CLKS - 1);

    logic [CNT_W-1:0] cnt_q;                    // Cycles left in this half period.

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cnt_q <= RELOAD;
        end else if (!i_run || (cnt_q == '0)) begin
            cnt_q <= RELOAD;                    // Idle or wrap, full period next.
        end else begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    assign o_tick = i_run && (cnt_q == '0);

endmodule

//--- rtl/spi_master.sv
`timescale 1ns/1ps

module spi_master import mmio_pkg::*; #(
    parameter int SCK_HALF_CLKS = 4             // Clk cycles per sck half period.
) (
    input  logic       clk,
    input  logic       i_arst_n,
    input  logic       i_start,                 // Begin a transfer, one cycle.
    input  logic [7:0] i_tx,                    // Byte to send.
    input  logic       i_miso,
    output logic       o_mosi,
    output logic       o_sck,
    output logic       o_ss_n,
    output logic       o_done,                  // Transfer complete, one cycle.
    output logic [7:0] o_rx                     // Byte received.
);
    spi_state_e state_q;
    logic [8:0] sh_q;                           // Tx on top, rx fills from bit 0.
    logic [2:0] bit_q;                          // Falling edges seen.
    logic       run;                            // Sck timer enable.
    logic       tick;                           // Half period over.

    assign run = (state_q == SPI_LEAD) || (state_q == SPI_HIGH) || (state_q == SPI_LOW);

    spi_sck_timer #(
        .SCK_HALF_CLKS (SCK_HALF_CLKS)
    ) u_sck_timer (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_run    (run),
        .o_tick   (tick)
    );

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= SPI_IDLE;
            bit_q   <= 3'd0;
        end else begin
            case (state_q)
                SPI_IDLE: begin
                    if (i_start) begin
                        state_q <= SPI_LEAD;    // Select the slave.
                        bit_q   <= 3'd0;
                    end
                end
                SPI_LEAD: begin
                    if (tick) begin
                        state_q <= SPI_HIGH;    // First rising edge.
                    end
                end
                SPI_HIGH: begin
                    if (tick) begin
                        bit_q   <= bit_q + 3'd1;  // Falling edge.
                        state_q <= SPI_LOW;
                    end
                end
                SPI_LOW: begin
                    if (tick) begin
                        if (bit_q == 3'd0) begin
                            state_q <= SPI_DONE;  // Low half after the eighth falling edge.
                        end else begin
                            state_q <= SPI_HIGH;
                        end
                    end
                end
                SPI_DONE: begin
                    state_q <= SPI_IDLE;        // One cycle, select released.
                end
                default: begin
                    state_q <= SPI_IDLE;
                end
            endcase
        end
    end

    // Mode 0. Sample at the rising edge, shift at the falling edge.
    always_ff @(posedge clk) begin
        if ((state_q == SPI_IDLE) && i_start) begin
            sh_q <= {i_tx, 1'b0};               // MSB first.
        end else if (tick && ((state_q == SPI_LEAD)
                              || ((state_q == SPI_LOW) && (bit_q != 3'd0)))) begin
            sh_q[0] <= i_miso;                  // Rising sck.
        end else if (tick && (state_q == SPI_HIGH)) begin
            sh_q <= {sh_q[7:0], 1'b0};          // Falling sck, next bit out.
        end
    end

    assign o_sck  = (state_q == SPI_HIGH);
    assign o_ss_n = (state_q == SPI_IDLE) || (state_q == SPI_DONE);
    assign o_mosi = run ? sh_q[8] : 1'b0;       // Low outside a transfer.
    assign o_done = (state_q == SPI_DONE);
    assign o_rx   = sh_q[8:1];                  // All eight rx bits moved up by now.

endmodule

//--- rtl/mem_map_spi.sv
`timescale 1ns/1ps

module mem_map_spi import mmio_pkg::*; (
    input  logic        clk,
    input  logic        i_arst_n,
    input  logic        i_wr,                   // Accepted register write.
    input  logic        i_rd,                   // Accepted register read.
    input  logic [31:0] i_addr,                 // Bus byte address.
    input  logic [31:0] i_wdata,                // Bus write data.
    input  logic        i_done,                 // Transfer finished.
    input  logic [7:0]  i_rx,                   // Received byte.
    output logic        o_busy,                 // Transfer in progress.
    output logic [31:0] o_rdata,                // Register read value.
    output logic        o_start,                // Start pulse to the master.
    output logic [7:0]  o_tx                    // Byte to send.
);
    logic        is_data;                       // Data register selected.
    logic        is_stat;                       // Status register selected.
    logic        busy_q;
    logic        ready_q;                       // Unread byte waiting.
    logic        start_q;
    logic [7:0]  tx_q;
    logic [7:0]  rx_q;                          // Last received byte.
    logic [31:0] rdata_q;

    assign is_data = (i_addr == IO_BASE + SPI_DATA_OFS);
    assign is_stat = (i_addr == IO_BASE + SPI_STAT_OFS);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            busy_q  <= 1'b0;
            ready_q <= 1'b0;
            start_q <= 1'b0;
        end else begin
            start_q <= i_wr && is_data;         // Master starts one cycle later.
            if (i_wr && is_data) begin
                busy_q <= 1'b1;                 // Busy from the accepting edge.
            end else if (i_done) begin
                busy_q <= 1'b0;
            end
            if (i_done) begin
                ready_q <= 1'b1;
            end else if (i_rd && is_data) begin
                ready_q <= 1'b0;                // Byte consumed.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_wr && is_data) begin
            tx_q <= i_wdata[7:0];
        end
        if (i_done) begin
            rx_q <= i_rx;
        end
        if (i_rd && is_data) begin
            rdata_q <= {24'h0, rx_q};
        end else if (i_rd && is_stat) begin
            rdata_q <= {30'h0, ready_q, busy_q};
        end
    end

    assign o_busy  = busy_q;
    assign o_rdata = rdata_q;
    assign o_start = start_q;
    assign o_tx    = tx_q;

endmodule

//--- rtl/riscv_mmio.sv
`timescale 1ns/1ps

module riscv_mmio import mmio_pkg::*; #(
    parameter int MEM_WORDS     = 256,          // Data memory depth in words.
    parameter int SCK_HALF_CLKS = 4             // Clk cycles per sck half period.
) (
    input  logic    clk,
    input  logic    i_arst_n,
    input  wb_req_t i_wb,                       // Wishbone slave request.
    output wb_rsp_t o_wb,                       // Wishbone slave response.
    input  logic    i_miso,
    output logic    o_mosi,
    output logic    o_sck,
    output logic    o_ss_n
);
    logic        mem_we;                        // Decoder to data memory.
    logic [3:0]  mem_sel;
    logic [31:0] mem_rdata;
    logic        spi_wr;                        // Decoder to SPI registers.
    logic        spi_rd;
    logic [31:0] spi_rdata;
    logic        spi_busy;
    logic        spi_start;                     // SPI registers to master.
    logic [7:0]  spi_tx;
    logic        spi_done;                      // Master back to registers.
    logic [7:0]  spi_rx;

    mem_map_io_dec #(
        .MEM_WORDS   (MEM_WORDS)
    ) u_io_dec (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_req       (i_wb),
        .i_mem_rdata (mem_rdata),
        .i_spi_rdata (spi_rdata),
        .i_spi_busy  (spi_busy),
        .o_mem_we    (mem_we),
        .o_mem_sel   (mem_sel),
        .o_spi_wr    (spi_wr),
        .o_spi_rd    (spi_rd),
        .o_rsp       (o_wb)
    );

    data_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) u_data_mem (
        .clk       (clk),
        .i_we      (mem_we),
        .i_sel     (mem_sel),
        .i_addr    (i_wb.adr),
        .i_wdata   (i_wb.dat),
        .o_rdata   (mem_rdata)
    );

    mem_map_spi u_spi_regs (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_wr     (spi_wr),
        .i_rd     (spi_rd),
        .i_addr   (i_wb.adr),
        .i_wdata  (i_wb.dat),
        .i_done   (spi_done),
        .i_rx     (spi_rx),
        .o_busy   (spi_busy),
        .o_rdata  (spi_rdata),
        .o_start  (spi_start),
        .o_tx     (spi_tx)
    );

    spi_master #(
        .SCK_HALF_CLKS (SCK_HALF_CLKS)
    ) u_spi_master (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_start  (spi_start),
        .i_tx     (spi_tx),
        .i_miso   (i_miso),
        .o_mosi   (o_mosi),
        .o_sck    (o_sck),
        .o_ss_n   (o_ss_n),
        .o_done   (spi_done),
        .o_rx     (spi_rx)
    );

endmodule

//--- bench/riscv_mmio_checker.sv
`timescale 1ns/1ps

module riscv_mmio_checker import mmio_pkg::*; #(
    parameter int MEM_WORDS     = 256,                    // Data memory depth in words.
    parameter int SCK_HALF_CLKS = 4                       // Clk cycles per sck half period.
) (
    input logic    clk,
    input logic    i_arst_n,
    input wb_req_t i_req,                                 // Bus request as driven.
    input wb_rsp_t i_rsp,                                 // DUT response.
    input logic    i_mosi,
    input logic    i_sck,
    input logic    i_ss_n
);
    // Edges that see busy after the accepting edge, start and done cycles included.
    localparam int XFER_EDGES = 17 * SCK_HALF_CLKS + 2;

    logic [31:0] shadow [MEM_WORDS];                      // Memory model, X until written.
    int          busy_cnt;                                // Busy edges still to come.
    logic        ready_m;
    logic [7:0]  tx_m;                                    // Last byte sent.
    logic [7:0]  rx_m;                                    // Loopback returns the sent byte.
    logic        exp_valid;                               // Response due at the next edge.
    logic        exp_rd;
    logic [31:0] exp_adr;
    wb_rsp_t     exp_q;
    int          check_cnt = 0;
    int          err_cnt   = 0;

    // Expected ack, err and read data from the memory map rules.
    function automatic wb_rsp_t expect_rsp(input wb_req_t req, input logic busy);
        wb_rsp_t r;
        logic    lanes_ok;
        logic    hit_data;
        logic    hit_stat;
        r        = '0;
        hit_data = (req.adr == IO_BASE + SPI_DATA_OFS);
        hit_stat = (req.adr == IO_BASE + SPI_STAT_OFS);
        lanes_ok = ((req.sel == 4'b1111) && (req.adr[1:0] == 2'd0))
                || ((req.sel == 4'b0011) && (req.adr[1:0] == 2'd0))
                || ((req.sel == 4'b1100) && (req.adr[1:0] == 2'd2))
                || (req.sel == (4'b0001 << req.adr[1:0]));
        if (req.adr[31]) begin
            r.err = !(hit_data || hit_stat) || (req.sel != 4'b1111)
                    || (req.we && hit_data && busy);
        end else begin
            r.err = (req.adr >= 32'(4 * MEM_WORDS)) || !lanes_ok;
        end
        r.ack = !r.err;
        if (r.ack && !req.we) begin
            if (!req.adr[31]) begin
                r.dat = shadow[req.adr >> 2];             // Whole word, whatever the lanes.
            end else if (hit_data) begin
                r.dat = {24'h0, rx_m};
            end else begin
                r.dat = {30'h0, ready_m, busy};
            end
        end
        return r;
    endfunction

    always @(posedge clk or negedge i_arst_n) begin
        wb_rsp_t rsp_exp;
        logic    busy_now;
        logic    rsp_seen;
        logic    hit_data;
        logic    exp_sck;
        logic    exp_ss_n;
        logic    exp_mosi;
        int      half;
        if (!i_arst_n) begin
            busy_cnt  = 0;
            ready_m   = 1'b0;
            exp_valid = 1'b0;
            rx_m      = 8'h0;
        end else begin
            busy_now = (busy_cnt > 0);
            rsp_seen = i_rsp.ack || i_rsp.err;
            hit_data = (i_req.adr == IO_BASE + SPI_DATA_OFS);
            if (exp_valid) begin
                check_cnt++;
                if (!rsp_seen) begin
                    err_cnt++;
                    $display("Error at %0t: no response to %h one cycle later", $time, exp_adr);
                end else if ((i_rsp.ack !== exp_q.ack) || (i_rsp.err !== exp_q.err)) begin
                    err_cnt++;
                    $display("Error at %0t: %h gave ack %b err %b, expected ack %b err %b",
                             $time, exp_adr, i_rsp.ack, i_rsp.err, exp_q.ack, exp_q.err);
                end else if (exp_rd && exp_q.ack && (i_rsp.dat !== exp_q.dat)) begin
                    err_cnt++;
                    $display("Error at %0t: read of %h gave %h, expected %h",
                             $time, exp_adr, i_rsp.dat, exp_q.dat);
                end
            end else if (rsp_seen) begin
                err_cnt++;
                $display("Error at %0t: response with no request pending", $time);
            end
            // Serial pins along the transfer, one half period per SCK_HALF_CLKS edges.
            exp_sck  = 1'b0;
            exp_ss_n = 1'b1;
            exp_mosi = 1'b0;
            if ((busy_cnt >= 2) && (busy_cnt < XFER_EDGES)) begin
                half     = (XFER_EDGES - 1 - busy_cnt) / SCK_HALF_CLKS;
                exp_sck  = half[0];                       // Lead half is low, then alternate.
                exp_ss_n = 1'b0;
                exp_mosi = (half < 16) ? tx_m[7 - half / 2] : i_mosi;  // Last low half is free.
            end
            if ({i_sck, i_ss_n, i_mosi} !== {exp_sck, exp_ss_n, exp_mosi}) begin
                err_cnt++;
                $display("Error at %0t: sck %b ss_n %b mosi %b, expected %b %b %b",
                         $time, i_sck, i_ss_n, i_mosi, exp_sck, exp_ss_n, exp_mosi);
            end
            exp_valid = i_req.cyc && i_req.stb && !rsp_seen;   // First cycle of a request.
            rsp_exp   = '0;
            if (exp_valid) begin
                rsp_exp = expect_rsp(i_req, busy_now);
                exp_q   = rsp_exp;
                exp_rd  = !i_req.we;
                exp_adr = i_req.adr;
                if (rsp_exp.ack && i_req.we && !i_req.adr[31]) begin
                    for (int b = 0; b < 4; b++) begin
                        if (i_req.sel[b]) begin
                            shadow[i_req.adr >> 2][8*b +: 8] = i_req.dat[8*b +: 8];
                        end
                    end
                end
                if (rsp_exp.ack && !i_req.we && hit_data) begin
                    ready_m = 1'b0;                       // Byte consumed.
                end
            end
            if (busy_cnt == 1) begin
                ready_m = 1'b1;                           // Done beats a read at this edge.
                rx_m    = tx_m;
            end
            if (busy_cnt > 0) begin
                busy_cnt--;
            end
            if (exp_valid && rsp_exp.ack && i_req.we && hit_data) begin
                tx_m     = i_req.dat[7:0];
                busy_cnt = XFER_EDGES;
            end
        end
    end

    task automatic report(input int timeouts, input int asrt_fails);
        $display("Checks: %0d, mismatches: %0d, timeouts: %0d, assertion failures: %0d",
                 check_cnt, err_cnt, timeouts, asrt_fails);
    endtask

endmodule

//--- bench/riscv_mmio_asserts.sv
`timescale 1ns/1ps

module riscv_mmio_asserts import mmio_pkg::*; (
    input logic    clk,
    input logic    i_arst_n,
    input wb_rsp_t i_rsp,                                 // Bus response.
    input logic    i_sck,
    input logic    i_ss_n,
    input logic    i_spi_start                            // Start pulse into the SPI master.
);
    int   both_fails = 0;
    int   len_fails  = 0;
    int   ss_fails   = 0;
    int   fail_cnt;                                       // Read by the testbench.
    logic started_q;                                      // Any SPI activity since reset.

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            started_q <= 1'b0;
        end else if (i_spi_start || i_sck) begin
            started_q <= 1'b1;
        end
    end

    assign fail_cnt = both_fails + len_fails + ss_fails;

    ack_err_excl: assert property (@(posedge clk) disable iff (!i_arst_n)
        !(i_rsp.ack && i_rsp.err))
        else begin
            both_fails++;
            $error("ack and err high in the same cycle");
        end

    rsp_one_cycle: assert property (@(posedge clk) disable iff (!i_arst_n)
        (i_rsp.ack || i_rsp.err) |=> !(i_rsp.ack || i_rsp.err))
        else begin
            len_fails++;
            $error("response held longer than one cycle");
        end

    ss_idle_high: assert property (@(posedge clk) disable iff (!i_arst_n)
        !started_q |-> i_ss_n)
        else begin
            ss_fails++;
            $error("ss_n low with no SPI transfer started since reset");
        end

endmodule

bind riscv_mmio riscv_mmio_asserts u_asserts (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_rsp       (o_wb),
    .i_sck       (o_sck),
    .i_ss_n      (o_ss_n),
    .i_spi_start (spi_start)
);

//--- bench/tb_riscv_mmio.sv
`timescale 1ns/1ps

module tb_riscv_mmio
    import mmio_pkg::*;
();
    localparam int MEM_WORDS     = 256;                   // Data memory depth in words.
    localparam int SCK_HALF_CLKS = 4;                     // Clk cycles per sck half period.
    localparam int RSP_TIMEOUT   = 10;                    // Cycles allowed for ack or err.
    localparam int SPI_TIMEOUT   = 40 * SCK_HALF_CLKS;    // Cycles allowed for SPI ready.

    logic        clk;
    logic        arst_n;
    wb_req_t     wb_req;                                  // Driven by the bus tasks.
    wb_rsp_t     wb_rsp;
    logic        mosi;                                    // Looped back into miso.
    logic        sck;
    logic        ss_n;
    int          tb_err    = 0;                           // Timeouts.
    int          cycle_cnt = 0;                           // Free running, for SPI polling.
    logic [31:0] word_q [$];                              // Word addresses already written.
    wb_rsp_t     rsp;

    riscv_mmio #(
        .MEM_WORDS     (MEM_WORDS),
        .SCK_HALF_CLKS (SCK_HALF_CLKS)
    ) u_riscv_mmio (
        .clk      (clk),
        .i_arst_n (arst_n),
        .i_wb     (wb_req),
        .o_wb     (wb_rsp),
        .i_miso   (mosi),
        .o_mosi   (mosi),
        .o_sck    (sck),
        .o_ss_n   (ss_n)
    );

    riscv_mmio_checker #(
        .MEM_WORDS     (MEM_WORDS),
        .SCK_HALF_CLKS (SCK_HALF_CLKS)
    ) u_checker (
        .clk      (clk),
        .i_arst_n (arst_n),
        .i_req    (wb_req),
        .i_rsp    (wb_rsp),
        .i_mosi   (mosi),
        .i_sck    (sck),
        .i_ss_n   (ss_n)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                           // 20 ns period.
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic end_run();
        int fails;
        fails = u_checker.err_cnt + u_riscv_mmio.u_asserts.fail_cnt + tb_err;
        u_checker.report(tb_err, u_riscv_mmio.u_asserts.fail_cnt);
        if (fails == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    // One Wishbone classic cycle. Request out at an edge, held until ack or err.
    task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                              input logic [3:0] sel, output wb_rsp_t r);
        wb_req_t req;
        bit      got;
        req = '{1'b1, 1'b1, we, adr, dat, sel};
        got = 1'b0;
        r   = '0;
        @(posedge clk);
        wb_req <= req;
        for (int n = 0; (n < RSP_TIMEOUT) && !got; n++) begin
            @(posedge clk);
            if (wb_rsp.ack || wb_rsp.err) begin
                got = 1'b1;
                r   = wb_rsp;
                wb_req <= '0;                             // Drop stb with the response.
            end
        end
        if (!got) begin
            tb_err++;
            $display("Timeout at %0t: no bus response to address %h", $time, adr);
            end_run();
        end
    endtask

    // Poll the status register until ready shows up.
    task automatic wait_spi_ready();
        wb_rsp_t r;
        int      start;
        start = cycle_cnt;
        r     = '0;
        while (!r.dat[1] && ((cycle_cnt - start) < SPI_TIMEOUT)) begin
            bus_access(1'b0, IO_BASE + SPI_STAT_OFS, 32'h0, 4'b1111, r);
        end
        if (!r.dat[1]) begin
            tb_err++;
            $display("Timeout at %0t: SPI ready not set after %0d cycles", $time, SPI_TIMEOUT);
            end_run();
        end
    endtask

    function automatic logic [3:0] sub_word_sel(input int k);
        case (k)
            0:       return 4'b0001;
            1:       return 4'b0010;
            2:       return 4'b0100;
            3:       return 4'b1000;
            4:       return 4'b0011;
            default: return 4'b1100;
        endcase
    endfunction

    // Lowest enabled lane gives the byte offset.
    function automatic logic [1:0] lane_offset(input logic [3:0] sel);
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                return 2'(b);
            end
        end
        return 2'd0;
    endfunction

    initial begin
        logic [31:0] adr;
        logic [3:0]  sel;
        logic [7:0]  tx_byte;
        void'($urandom(52403));                           // Only seeding point.
        arst_n = 1'b0;
        wb_req = '0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < 16; i++) begin                // Random word writes.
            adr = ($urandom % MEM_WORDS) << 2;
            word_q.push_back(adr);
            bus_access(1'b1, adr, $urandom, 4'b1111, rsp);
        end
        foreach (word_q[i]) begin                         // Read them all back.
            bus_access(1'b0, word_q[i], 32'h0, 4'b1111, rsp);
        end
        for (int i = 0; i < 16; i++) begin                // Byte and halfword writes.
            sel = sub_word_sel($urandom % 6);
            adr = word_q[$urandom % word_q.size()] + lane_offset(sel);
            bus_access(1'b1, adr, $urandom, sel, rsp);
            bus_access(1'b0, {adr[31:2], 2'b00}, 32'h0, 4'b1111, rsp);
        end
        adr = word_q[0];                                  // Illegal accesses on a known word.
        bus_access(1'b1, adr, 32'hFFFF_FFFF, 4'b0000, rsp);
        bus_access(1'b1, adr, 32'hFFFF_FFFF, 4'b0101, rsp);
        bus_access(1'b1, adr + 1, 32'hFFFF_FFFF, 4'b0110, rsp);
        bus_access(1'b1, adr + 2, 32'hFFFF_FFFF, 4'b0011, rsp);
        bus_access(1'b1, adr, 32'hFFFF_FFFF, 4'b1100, rsp);
        bus_access(1'b1, adr + 1, 32'hFFFF_FFFF, 4'b1111, rsp);
        bus_access(1'b1, adr + 2, 32'hFFFF_FFFF, 4'b0001, rsp);
        bus_access(1'b0, adr, 32'h0, 4'b0111, rsp);
        bus_access(1'b1, 32'(4 * MEM_WORDS), 32'hFFFF_FFFF, 4'b1111, rsp);
        bus_access(1'b0, 32'h7FFF_FFF0, 32'h0, 4'b1111, rsp);
        bus_access(1'b1, IO_BASE + 32'h8, 32'hFFFF_FFFF, 4'b1111, rsp);
        bus_access(1'b1, IO_BASE + SPI_DATA_OFS, 32'hFF, 4'b0001, rsp);   // Byte to SPI.
        bus_access(1'b0, adr, 32'h0, 4'b1111, rsp);
        tx_byte = 8'($urandom);                           // Single loopback transfer.
        bus_access(1'b1, IO_BASE + SPI_DATA_OFS, {24'h0, tx_byte}, 4'b1111, rsp);
        wait_spi_ready();
        bus_access(1'b0, IO_BASE + SPI_DATA_OFS, 32'h0, 4'b1111, rsp);
        bus_access(1'b0, IO_BASE + SPI_STAT_OFS, 32'h0, 4'b1111, rsp);
        tx_byte = 8'($urandom);                           // Second write lands while busy.
        bus_access(1'b1, IO_BASE + SPI_DATA_OFS, {24'h0, tx_byte}, 4'b1111, rsp);
        bus_access(1'b1, IO_BASE + SPI_DATA_OFS, {24'h0, ~tx_byte}, 4'b1111, rsp);
        wait_spi_ready();
        bus_access(1'b0, IO_BASE + SPI_DATA_OFS, 32'h0, 4'b1111, rsp);
        bus_access(1'b0, IO_BASE + SPI_STAT_OFS, 32'h0, 4'b1111, rsp);
        repeat (2) @(posedge clk);                        // Let the checker see the last response.
        end_run();
    end

endmodule

//--- src.f
rtl/mmio_pkg.sv
rtl/mem_map_io_dec.sv
rtl/data_mem.sv
rtl/spi_sck_timer.sv
rtl/spi_master.sv
rtl/mem_map_spi.sv
rtl/riscv_mmio.sv
bench/riscv_mmio_checker.sv
bench/riscv_mmio_asserts.sv
bench/tb_riscv_mmio.sv
